// File: mem_subsys.f
logic/mem_pkg.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/bus_arbiter.sv
logic/sram_slave.sv
logic/mem_subsys.sv
tests/mem_subsys_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mem_subsys_tb
FILELIST = mem_subsys.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

$(BUILD)/$(TOP): $(FILELIST) logic/*.sv tests/*.sv
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)

test: $(BUILD)/$(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tests/mem_subsys_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys_tb;

	// op counts set the run length and so the timeout
	localparam int init_ops = 256;
	localparam int mixed_ops = 2000;
	localparam int oor_ops = 16;
	// worst op is a round trip or a contended pair
	localparam int op_cycles = 20;
	localparam int timeout_cycles = (init_ops + mixed_ops) * op_cycles * 4 / 3;

	logic clk;
	logic rst;
	logic fetch_start;
	mem_pkg::fetch_req_t fetch_req;
	logic ls_start;
	mem_pkg::ls_req_t ls_req;
	logic fetch_busy;
	logic fetch_done;
	logic [31:0] inst;
	logic fetch_err;
	logic ls_busy;
	logic ls_done;
	logic [63:0] load_data;
	logic ls_err;

	// byte image of the 2 KiB sram
	logic [7:0] model [0:2047];
	integer seed;
	int cycles = 0;
	string cur_test = "reset";
	int test_checks = 0;
	int test_errors = 0;
	int tests_run = 0;
	int total_checks = 0;
	int total_errors = 0;

	mem_subsys u_dut (
		.clk        (clk),
		.rst        (rst),
		.fetch_start(fetch_start),
		.fetch_req  (fetch_req),
		.ls_start   (ls_start),
		.ls_req     (ls_req),
		.fetch_busy (fetch_busy),
		.fetch_done (fetch_done),
		.inst       (inst),
		.fetch_err  (fetch_err),
		.ls_busy    (ls_busy),
		.ls_done    (ls_done),
		.load_data  (load_data),
		.ls_err     (ls_err)
	);

	always #5 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("timeout after %0d cycles, test %s never finished", cycles, cur_test);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//******************************
	// reference model
	//******************************
	function automatic int size_bytes(mem_pkg::access_size_t s);
		case (s)
			mem_pkg::size_byte: return 1;
			mem_pkg::size_half: return 2;
			mem_pkg::size_word: return 4;
			default: return 8;
		endcase
	endfunction

	function automatic logic in_range(logic [31:0] a);
		return a[31:11] == 21'd0;
	endfunction

	// natural alignment for a size
	function automatic logic [31:0] align_addr(logic [31:0] a, mem_pkg::access_size_t s);
		case (s)
			mem_pkg::size_byte: return a;
			mem_pkg::size_half: return {a[31:1], 1'b0};
			mem_pkg::size_word: return {a[31:2], 2'b00};
			default: return {a[31:3], 3'b000};
		endcase
	endfunction

	// little endian gather, then extend from the top loaded byte
	function automatic logic [63:0] expected_load(logic [31:0] a,
		mem_pkg::access_size_t s, logic sgn);
		logic [63:0] v;
		int n;
		v = 64'd0;
		n = size_bytes(s);
		if (!in_range(a))
			return v;
		for (int i = 0; i < n; i++)
			v[8*i +: 8] = model[a[10:0] + 11'(i)];
		if (sgn && v[8*n-1]) begin
			for (int i = n; i < 8; i++)
				v[8*i +: 8] = 8'hff;
		end
		return v;
	endfunction

	function automatic logic [31:0] expected_inst(logic [31:0] pc);
		logic [10:0] a;
		a = pc[10:0];
		if (!in_range(pc))
			return 32'd0;
		return {model[a + 11'd3], model[a + 11'd2], model[a + 11'd1], model[a]};
	endfunction

	//******************************
	// drivers and checks
	//******************************
	task automatic report_mismatch(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
		test_errors++;
	endtask

	task automatic finish_test();
		$display("%s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
		tests_run++;
		total_checks += test_checks;
		total_errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	task automatic set_ls_req(input logic [31:0] a, input mem_pkg::access_size_t s,
		input logic store, input logic sgn, input logic [63:0] d);
		ls_req.addr = a;
		ls_req.wdata = d;
		ls_req.size = s;
		ls_req.is_store = store;
		ls_req.is_signed = sgn;
	endtask

	// one load/store access, called on a falling edge
	task automatic ls_access(input logic [31:0] a, input mem_pkg::access_size_t s,
		input logic store, input logic sgn, input logic [63:0] d);
		while (ls_busy)
			@(negedge clk);
		set_ls_req(a, s, store, sgn, d);
		ls_start = 1'b1;
		@(negedge clk);
		ls_start = 1'b0;
		while (!ls_done)
			@(negedge clk);
	endtask

	task automatic store_op(input logic [31:0] a, input mem_pkg::access_size_t s,
		input logic [63:0] d);
		logic exp_err;
		exp_err = !in_range(a);
		ls_access(a, s, 1'b1, 1'b0, d);
		test_checks++;
		if (ls_err !== exp_err)
			report_mismatch("store ls_err", {63'd0, exp_err}, {63'd0, ls_err});
		// only the strobed lanes change
		if (!exp_err) begin
			for (int i = 0; i < size_bytes(s); i++)
				model[a[10:0] + 11'(i)] = d[8*i +: 8];
		end
	endtask

	task automatic load_op(input logic [31:0] a, input mem_pkg::access_size_t s,
		input logic sgn);
		logic [63:0] exp_data;
		logic exp_err;
		exp_data = expected_load(a, s, sgn);
		exp_err = !in_range(a);
		ls_access(a, s, 1'b0, sgn, 64'd0);
		test_checks += 2;
		if (load_data !== exp_data)
			report_mismatch("load_data", exp_data, load_data);
		if (ls_err !== exp_err)
			report_mismatch("load ls_err", {63'd0, exp_err}, {63'd0, ls_err});
	endtask

	task automatic fetch_op(input logic [31:0] pc);
		logic [31:0] exp_inst;
		logic exp_err;
		exp_inst = expected_inst(pc);
		exp_err = !in_range(pc);
		while (fetch_busy)
			@(negedge clk);
		fetch_req.pc = pc;
		fetch_start = 1'b1;
		@(negedge clk);
		fetch_start = 1'b0;
		while (!fetch_done)
			@(negedge clk);
		test_checks += 2;
		if (inst !== exp_inst)
			report_mismatch("inst", {32'd0, exp_inst}, {32'd0, inst});
		if (fetch_err !== exp_err)
			report_mismatch("fetch_err", {63'd0, exp_err}, {63'd0, fetch_err});
	endtask

	// fetch and load started together, done order free
	task automatic contention_op(input logic [31:0] pc, input logic [31:0] a,
		input mem_pkg::access_size_t s, input logic sgn);
		logic [31:0] exp_inst;
		logic [63:0] exp_data;
		logic got_fetch;
		logic got_load;
		exp_inst = expected_inst(pc);
		exp_data = expected_load(a, s, sgn);
		got_fetch = 1'b0;
		got_load = 1'b0;
		while (fetch_busy || ls_busy)
			@(negedge clk);
		fetch_req.pc = pc;
		set_ls_req(a, s, 1'b0, sgn, 64'd0);
		fetch_start = 1'b1;
		ls_start = 1'b1;
		@(negedge clk);
		fetch_start = 1'b0;
		ls_start = 1'b0;
		while (!(got_fetch && got_load)) begin
			if (fetch_done) begin
				got_fetch = 1'b1;
				test_checks++;
				if (inst !== exp_inst)
					report_mismatch("contended inst", {32'd0, exp_inst}, {32'd0, inst});
			end
			if (ls_done) begin
				got_load = 1'b1;
				test_checks++;
				if (load_data !== exp_data)
					report_mismatch("contended load_data", exp_data, load_data);
			end
			@(negedge clk);
		end
	endtask

	//******************************
	// test sequence
	//******************************
	initial begin
		logic [31:0] r0;
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] addr;
		logic [31:0] pc;
		mem_pkg::access_size_t sz;
		seed = 88;
		clk = 1'b0;
		rst = 1'b1;
		fetch_start = 1'b0;
		fetch_req = '0;
		ls_start = 1'b0;
		ls_req = '0;
		repeat (10)
			@(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		cur_test = "reset";
		test_checks += 4;
		if (fetch_busy !== 1'b0)
			report_mismatch("fetch_busy", 64'd0, {63'd0, fetch_busy});
		if (ls_busy !== 1'b0)
			report_mismatch("ls_busy", 64'd0, {63'd0, ls_busy});
		if (fetch_done !== 1'b0)
			report_mismatch("fetch_done", 64'd0, {63'd0, fetch_done});
		if (ls_done !== 1'b0)
			report_mismatch("ls_done", 64'd0, {63'd0, ls_done});
		finish_test();

		// every word written once so loads never see X
		cur_test = "init";
		for (int i = 0; i < init_ops; i++) begin
			r0 = $random(seed);
			r1 = $random(seed);
			store_op({21'd0, 8'(i), 3'b000}, mem_pkg::size_dword, {r0, r1});
		end
		finish_test();

		// r0 op code, size, sign, address and pc; r1 r2 data
		cur_test = "mixed";
		for (int n = 0; n < mixed_ops; n++) begin
			r0 = $random(seed);
			r1 = $random(seed);
			r2 = $random(seed);
			sz = mem_pkg::access_size_t'(r0[4:3]);
			addr = align_addr({21'd0, r0[16:6]}, sz);
			pc = {21'd0, r0[25:17], 2'b00};
			case (r0[2:0])
				3'd0: begin
					addr = align_addr(addr, mem_pkg::size_dword);
					store_op(addr, mem_pkg::size_dword, {r1, r2});
					load_op(addr, mem_pkg::size_dword, r0[5]);
				end
				3'd1, 3'd2: store_op(addr, sz, {r1, r2});
				3'd3, 3'd4: load_op(addr, sz, r0[5]);
				3'd5: fetch_op(pc);
				default: contention_op(pc, addr, sz, r0[5]);
			endcase
		end
		finish_test();

		// high address bits forced nonzero
		cur_test = "out_of_range";
		for (int n = 0; n < oor_ops; n++) begin
			r0 = $random(seed);
			r1 = $random(seed);
			r2 = $random(seed);
			sz = mem_pkg::access_size_t'(r0[4:3]);
			addr = align_addr({r1[31:11] | 21'd1, r0[16:6]}, sz);
			store_op(addr, sz, {r1, r2});
			load_op(addr, sz, r0[5]);
			// same low bits in range, still the old contents
			load_op({21'd0, addr[10:0]}, sz, r0[5]);
			fetch_op({r2[31:11] | 21'd1, r0[26:18], 2'b00});
		end
		finish_test();

		$display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: logic/mem_subsys.sv
`timescale 1ns/1ns
`default_nettype none

module mem_subsys (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 fetch_start,
	input  mem_pkg::fetch_req_t fetch_req,
	input  wire                 ls_start,
	input  mem_pkg::ls_req_t    ls_req,
	output logic                fetch_busy,
	output logic                fetch_done,
	output logic [31:0]         inst,
	output logic                fetch_err,
	output logic                ls_busy,
	output logic                ls_done,
	output logic [63:0]         load_data,
	output logic                ls_err
);

	//******************************
	// client side read channels
	//******************************
	mem_pkg::axi_ar_t fetch_ar;
	mem_pkg::axi_ar_t ls_ar;
	mem_pkg::axi_r_t fetch_r;
	mem_pkg::axi_r_t ls_r;
	logic fetch_ar_valid;
	logic fetch_ar_ready;
	logic fetch_r_valid;
	logic fetch_r_ready;
	logic ls_ar_valid;
	logic ls_ar_ready;
	logic ls_r_valid;
	logic ls_r_ready;

	//******************************
	// sram side channels
	//******************************
	mem_pkg::axi_ar_t mem_ar;
	mem_pkg::axi_r_t mem_r;
	mem_pkg::axi_aw_t mem_aw;
	mem_pkg::axi_w_t mem_w;
	mem_pkg::axi_b_t mem_b;
	logic mem_ar_valid;
	logic mem_ar_ready;
	logic mem_r_valid;
	logic mem_r_ready;
	logic mem_aw_valid;
	logic mem_aw_ready;
	logic mem_w_valid;
	logic mem_w_ready;
	logic mem_b_valid;
	logic mem_b_ready;

	fetch_unit u_fetch (
		.clk        (clk),
		.rst        (rst),
		.fetch_start(fetch_start),
		.fetch_req  (fetch_req),
		.ar_ready   (fetch_ar_ready),
		.r          (fetch_r),
		.r_valid    (fetch_r_valid),
		.ar         (fetch_ar),
		.ar_valid   (fetch_ar_valid),
		.r_ready    (fetch_r_ready),
		.busy       (fetch_busy),
		.fetch_done (fetch_done),
		.inst       (inst),
		.fetch_err  (fetch_err)
	);

	// writes bypass the arbiter, only this client stores
	load_store_unit u_lsu (
		.clk      (clk),
		.rst      (rst),
		.ls_start (ls_start),
		.ls_req   (ls_req),
		.ar_ready (ls_ar_ready),
		.r        (ls_r),
		.r_valid  (ls_r_valid),
		.aw_ready (mem_aw_ready),
		.w_ready  (mem_w_ready),
		.b        (mem_b),
		.b_valid  (mem_b_valid),
		.ar       (ls_ar),
		.ar_valid (ls_ar_valid),
		.r_ready  (ls_r_ready),
		.aw       (mem_aw),
		.aw_valid (mem_aw_valid),
		.w        (mem_w),
		.w_valid  (mem_w_valid),
		.b_ready  (mem_b_ready),
		.busy     (ls_busy),
		.ls_done  (ls_done),
		.load_data(load_data),
		.ls_err   (ls_err)
	);

	bus_arbiter u_arb (
		.clk           (clk),
		.rst           (rst),
		.fetch_ar      (fetch_ar),
		.fetch_ar_valid(fetch_ar_valid),
		.ls_ar         (ls_ar),
		.ls_ar_valid   (ls_ar_valid),
		.fetch_r_ready (fetch_r_ready),
		.ls_r_ready    (ls_r_ready),
		.mem_ar_ready  (mem_ar_ready),
		.mem_r         (mem_r),
		.mem_r_valid   (mem_r_valid),
		.fetch_ar_ready(fetch_ar_ready),
		.ls_ar_ready   (ls_ar_ready),
		.mem_ar        (mem_ar),
		.mem_ar_valid  (mem_ar_valid),
		.fetch_r       (fetch_r),
		.fetch_r_valid (fetch_r_valid),
		.ls_r          (ls_r),
		.ls_r_valid    (ls_r_valid),
		.mem_r_ready   (mem_r_ready)
	);

	sram_slave u_sram (
		.clk     (clk),
		.rst     (rst),
		.ar      (mem_ar),
		.ar_valid(mem_ar_valid),
		.aw      (mem_aw),
		.aw_valid(mem_aw_valid),
		.w       (mem_w),
		.w_valid (mem_w_valid),
		.r_ready (mem_r_ready),
		.b_ready (mem_b_ready),
		.ar_ready(mem_ar_ready),
		.aw_ready(mem_aw_ready),
		.w_ready (mem_w_ready),
		.r       (mem_r),
		.r_valid (mem_r_valid),
		.b       (mem_b),
		.b_valid (mem_b_valid)
	);

endmodule

`default_nettype wire

// File: logic/sram_slave.sv
`timescale 1ns/1ns
`default_nettype none

module sram_slave (
	input  wire              clk,
	input  wire              rst,
	input  mem_pkg::axi_ar_t ar,
	input  wire              ar_valid,
	input  mem_pkg::axi_aw_t aw,
	input  wire              aw_valid,
	input  mem_pkg::axi_w_t  w,
	input  wire              w_valid,
	input  wire              r_ready,
	input  wire              b_ready,
	output logic             ar_ready,
	output logic             aw_ready,
	output logic             w_ready,
	output mem_pkg::axi_r_t  r,
	output logic             r_valid,
	output mem_pkg::axi_b_t  b,
	output logic             b_valid
);

	logic [63:0] mem [mem_pkg::mem_words];
	logic pending;
	logic wr_take;
	logic rd_take;
	logic rd_in_range;
	logic wr_in_range;
	logic [mem_pkg::mem_addr_bits-4:0] rd_idx;
	logic [mem_pkg::mem_addr_bits-4:0] wr_idx;

	// one transaction in flight
	assign pending = r_valid || b_valid;

	// write wants aw and w in the same cycle and beats a read
	assign aw_ready = !pending && w_valid;
	assign w_ready = !pending && aw_valid;
	assign ar_ready = !pending && !(aw_valid && w_valid);
	assign wr_take = !pending && aw_valid && w_valid;
	assign rd_take = ar_valid && ar_ready;

	//******************************
	// address decode
	//******************************
	assign rd_idx = ar.addr[mem_pkg::mem_addr_bits-1:3];
	assign wr_idx = aw.addr[mem_pkg::mem_addr_bits-1:3];
	// anything from 2 KiB up is out of range
	assign rd_in_range = (ar.addr[31:mem_pkg::mem_addr_bits] == '0);
	assign wr_in_range = (aw.addr[31:mem_pkg::mem_addr_bits] == '0);

	// storage written per byte lane by strobe
	always_ff @(posedge clk) begin
		if (wr_take && wr_in_range) begin
			for (int i = 0; i < 8; i++) begin
				if (w.strb[i])
					mem[wr_idx][8*i +: 8] <= w.data[8*i +: 8];
			end
		end
	end

	//******************************
	// response registers
	//******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			r_valid <= 1'b0;
			r <= '0;
			b_valid <= 1'b0;
			b <= '0;
		end else begin
			// responses clear on their handshake
			if (r_valid && r_ready)
				r_valid <= 1'b0;
			if (b_valid && b_ready)
				b_valid <= 1'b0;
			if (wr_take) begin
				b_valid <= 1'b1;
				b.resp <= wr_in_range ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
			end else if (rd_take) begin
				r_valid <= 1'b1;
				r.data <= rd_in_range ? mem[rd_idx] : 64'd0;
				r.resp <= rd_in_range ? mem_pkg::resp_okay : mem_pkg::resp_slverr;
			end
		end
	end

	// write address and data always arrive as a pair
	a_aw_with_w: assert property (@(posedge clk) disable iff (rst)
		(aw_valid || w_valid) |-> (aw_valid && w_valid));

endmodule

`default_nettype wire

// File: logic/bus_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module bus_arbiter (
	input  wire              clk,
	input  wire              rst,
	input  mem_pkg::axi_ar_t fetch_ar,
	input  wire              fetch_ar_valid,
	input  mem_pkg::axi_ar_t ls_ar,
	input  wire              ls_ar_valid,
	input  wire              fetch_r_ready,
	input  wire              ls_r_ready,
	input  wire              mem_ar_ready,
	input  mem_pkg::axi_r_t  mem_r,
	input  wire              mem_r_valid,
	output logic             fetch_ar_ready,
	output logic             ls_ar_ready,
	output mem_pkg::axi_ar_t mem_ar,
	output logic             mem_ar_valid,
	output mem_pkg::axi_r_t  fetch_r,
	output logic             fetch_r_valid,
	output mem_pkg::axi_r_t  ls_r,
	output logic             ls_r_valid,
	output logic             mem_r_ready
);

	typedef enum logic [1:0] {
		gnt_none,
		gnt_fetch,
		gnt_ls
	} grant_t;

	grant_t grant;
	logic idle;
	// load/store has fixed priority while idle
	logic pick_ls;
	logic ar_fire;
	logic r_fire;

	assign idle = (grant == gnt_none);
	assign pick_ls = ls_ar_valid;

	//******************************
	// address channel
	//******************************
	assign mem_ar = pick_ls ? ls_ar : fetch_ar;
	assign mem_ar_valid = idle && (ls_ar_valid || fetch_ar_valid);
	// loser sees ready low and keeps its valid up
	assign ls_ar_ready = idle && pick_ls && mem_ar_ready;
	assign fetch_ar_ready = idle && !pick_ls && mem_ar_ready;
	assign ar_fire = mem_ar_valid && mem_ar_ready;

	//******************************
	// read response channel
	//******************************
	// payload goes to both but valid only to the owner
	assign fetch_r = mem_r;
	assign ls_r = mem_r;
	assign fetch_r_valid = mem_r_valid && (grant == gnt_fetch);
	assign ls_r_valid = mem_r_valid && (grant == gnt_ls);

	always_comb begin
		case (grant)
			gnt_fetch: mem_r_ready = fetch_r_ready;
			gnt_ls: mem_r_ready = ls_r_ready;
			default: mem_r_ready = 1'b0;
		endcase
	end

	assign r_fire = mem_r_valid && mem_r_ready;

	// grant held from ar handshake to r handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			grant <= gnt_none;
		end else if (idle) begin
			if (ar_fire)
				grant <= pick_ls ? gnt_ls : gnt_fetch;
		end else if (r_fire) begin
			grant <= gnt_none;
		end
	end

	// every memory response reaches exactly one client
	a_one_owner: assert property (@(posedge clk) disable iff (rst)
		mem_r_valid |-> $onehot({fetch_r_valid, ls_r_valid}));

endmodule

`default_nettype wire

// File: logic/load_store_unit.sv
`timescale 1ns/1ns
`default_nettype none

module load_store_unit (
	input  wire               clk,
	input  wire               rst,
	input  wire               ls_start,
	input  mem_pkg::ls_req_t  ls_req,
	input  wire               ar_ready,
	input  mem_pkg::axi_r_t   r,
	input  wire               r_valid,
	input  wire               aw_ready,
	input  wire               w_ready,
	input  mem_pkg::axi_b_t   b,
	input  wire               b_valid,
	output mem_pkg::axi_ar_t  ar,
	output logic              ar_valid,
	output logic              r_ready,
	output mem_pkg::axi_aw_t  aw,
	output logic              aw_valid,
	output mem_pkg::axi_w_t   w,
	output logic              w_valid,
	output logic              b_ready,
	output logic              busy,
	output logic              ls_done,
	output logic [63:0]       load_data,
	output logic              ls_err
);

	typedef enum logic [2:0] {
		st_idle,
		st_rd_addr,
		st_rd_resp,
		st_wr_addr,
		st_wr_resp
	} state_t;

	state_t state;
	mem_pkg::ls_req_t req_q;
	// aw and w may be taken in different cycles
	logic aw_sent;
	logic w_sent;
	logic aw_fire;
	logic w_fire;
	logic [5:0] lane_shift;
	logic [7:0] size_strb;
	logic [63:0] lane_data;

	// sign or zero extend the low bytes of a lane
	function automatic logic [63:0] extend(logic [63:0] d, mem_pkg::access_size_t s,
		logic sgn);
		case (s)
			mem_pkg::size_byte: extend = {{56{sgn & d[7]}}, d[7:0]};
			mem_pkg::size_half: extend = {{48{sgn & d[15]}}, d[15:0]};
			mem_pkg::size_word: extend = {{32{sgn & d[31]}}, d[31:0]};
			default: extend = d;
		endcase
	endfunction

	// natural alignment per access size
	function automatic logic is_aligned(logic [2:0] a, mem_pkg::access_size_t s);
		case (s)
			mem_pkg::size_byte: is_aligned = 1'b1;
			mem_pkg::size_half: is_aligned = (a[0] == 1'b0);
			mem_pkg::size_word: is_aligned = (a[1:0] == 2'b00);
			default: is_aligned = (a == 3'b000);
		endcase
	endfunction

	//******************************
	// lane steering
	//******************************
	assign lane_shift = {req_q.addr[2:0], 3'b000};

	always_comb begin
		case (req_q.size)
			mem_pkg::size_byte: size_strb = 8'h01;
			mem_pkg::size_half: size_strb = 8'h03;
			mem_pkg::size_word: size_strb = 8'h0f;
			default: size_strb = 8'hff;
		endcase
	end

	// both channels address whole double words
	assign ar.addr = {req_q.addr[31:3], 3'b000};
	assign aw.addr = {req_q.addr[31:3], 3'b000};
	assign w.data = req_q.wdata << lane_shift;
	assign w.strb = size_strb << req_q.addr[2:0];
	// load lane back down to bit 0
	assign lane_data = r.data >> lane_shift;

	assign ar_valid = (state == st_rd_addr);
	assign aw_valid = (state == st_wr_addr) && !aw_sent;
	assign w_valid = (state == st_wr_addr) && !w_sent;
	assign r_ready = (state == st_rd_resp);
	assign b_ready = (state == st_wr_resp);
	assign busy = (state != st_idle);
	assign aw_fire = aw_valid && aw_ready;
	assign w_fire = w_valid && w_ready;

	//******************************
	// control fsm
	//******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			aw_sent <= 1'b0;
			w_sent <= 1'b0;
			ls_done <= 1'b0;
			ls_err <= 1'b0;
		end else begin
			ls_done <= 1'b0;
			case (state)
				st_idle: begin
					aw_sent <= 1'b0;
					w_sent <= 1'b0;
					if (ls_start)
						state <= ls_req.is_store ? st_wr_addr : st_rd_addr;
				end
				st_rd_addr: begin
					if (ar_ready)
						state <= st_rd_resp;
				end
				st_rd_resp: begin
					if (r_valid) begin
						ls_done <= 1'b1;
						ls_err <= (r.resp != mem_pkg::resp_okay);
						state <= st_idle;
					end
				end
				st_wr_addr: begin
					if (aw_fire)
						aw_sent <= 1'b1;
					if (w_fire)
						w_sent <= 1'b1;
					// leave once both halves of the write are in
					if ((aw_sent || aw_fire) && (w_sent || w_fire))
						state <= st_wr_resp;
				end
				st_wr_resp: begin
					if (b_valid) begin
						ls_done <= 1'b1;
						ls_err <= (b.resp != mem_pkg::resp_okay);
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request and load result payloads
	always_ff @(posedge clk) begin
		if (ls_start && !busy)
			req_q <= ls_req;
		if (r_valid && r_ready)
			load_data <= extend(lane_data, req_q.size, req_q.is_signed);
	end

	// misaligned access is not handled anywhere downstream
	a_aligned: assert property (@(posedge clk) disable iff (rst)
		ls_start |-> is_aligned(ls_req.addr[2:0], ls_req.size));

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
	input  wire                 clk,
	input  wire                 rst,
	input  wire                 fetch_start,
	input  mem_pkg::fetch_req_t fetch_req,
	input  wire                 ar_ready,
	input  mem_pkg::axi_r_t     r,
	input  wire                 r_valid,
	output mem_pkg::axi_ar_t    ar,
	output logic                ar_valid,
	output logic                r_ready,
	output logic                busy,
	output logic                fetch_done,
	output logic [31:0]         inst,
	output logic                fetch_err
);

	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_resp
	} state_t;

	state_t state;
	// pc bit 2 picks the upper instruction of the double word
	logic upper_half;

	assign ar_valid = (state == st_addr);
	assign r_ready = (state == st_resp);
	assign busy = (state != st_idle);

	//******************************
	// control fsm
	//******************************
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			fetch_done <= 1'b0;
			fetch_err <= 1'b0;
		end else begin
			// done is a single cycle pulse
			fetch_done <= 1'b0;
			case (state)
				st_idle: begin
					if (fetch_start)
						state <= st_addr;
				end
				st_addr: begin
					if (ar_ready)
						state <= st_resp;
				end
				st_resp: begin
					if (r_valid) begin
						fetch_done <= 1'b1;
						fetch_err <= (r.resp != mem_pkg::resp_okay);
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// request payload, captured on start
	always_ff @(posedge clk) begin
		if (fetch_start && !busy) begin
			// bus address rounded down to the double word
			ar.addr <= {fetch_req.pc[31:3], 3'b000};
			upper_half <= fetch_req.pc[2];
		end
	end

	// instruction out of the returned beat
	always_ff @(posedge clk) begin
		if (r_valid && r_ready)
			inst <= upper_half ? r.data[63:32] : r.data[31:0];
	end

	// no new fetch until the last one is done
	a_start_idle: assert property (@(posedge clk) disable iff (rst)
		fetch_start |-> !busy);

	// instructions sit on 4-byte boundaries
	a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
		fetch_start |-> (fetch_req.pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

	//******************************
	// memory geometry
	//******************************

	// sram depth in 64-bit words
	localparam int mem_words = 256;
	// byte address bits that land inside the sram, 2 KiB
	localparam int mem_addr_bits = 11;

	// response codes, same encoding as axi
	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	//******************************
	// bus channel payloads
	//******************************

	// read address, always one 64-bit beat
	typedef struct packed {
		logic [31:0] addr;
	} axi_ar_t;

	// write address
	typedef struct packed {
		logic [31:0] addr;
	} axi_aw_t;

	// write data with byte strobes
	typedef struct packed {
		logic [63:0] data;
		logic [7:0]  strb;
	} axi_w_t;

	// read response
	typedef struct packed {
		logic [63:0] data;
		logic [1:0]  resp;
	} axi_r_t;

	// write response
	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	//******************************
	// client requests
	//******************************

	typedef enum logic [1:0] {
		size_byte,
		size_half,
		size_word,
		size_dword
	} access_size_t;

	// one load or store from the memory stage
	typedef struct packed {
		logic [31:0]  addr;
		logic [63:0]  wdata;
		access_size_t size;
		logic         is_store;
		// sign extend loads when set
		logic         is_signed;
	} ls_req_t;

	typedef struct packed {
		logic [31:0] pc;
	} fetch_req_t;

endpackage

`default_nettype wire
